// File: verilog/idu_pkg.sv
package idu_pkg;

    localparam int XLEN         = 32;
    localparam int REG_ADDR_LEN = 5;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Same values as the branch funct3
    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd4,
        CMP_GE  = 3'd5,
        CMP_LTU = 3'd6,
        CMP_GEU = 3'd7
    } cmp_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    rs2_imm_sel;
        logic    pc_imm_sel;
        logic    rs1_zero_sel;
        logic    branch;
        cmp_op_e cmp_op;
        logic    jump;
        logic    jump_alu;
    } exe_ctrl_t;

    typedef struct packed {
        logic       mem_req;
        logic       mem_wr;
        logic [3:0] mem_byte;
        logic       mem_sign_ext;
    } mem_ctrl_t;

    typedef struct packed {
        logic rd_wr;
        logic mem_cal_sel;
    } wb_ctrl_t;

    typedef struct packed {
        logic                    wr;
        logic [REG_ADDR_LEN-1:0] addr;
        logic [XLEN-1:0]         wdata;
    } dbg_req_t;

endpackage

// File: verilog/rfu.sv
module rfu
    import idu_pkg::*;
(
    input                           clk,
    input                           rst_n_i,
    input        [REG_ADDR_LEN-1:0] rs1_addr_i,
    input        [REG_ADDR_LEN-1:0] rs2_addr_i,
    output logic [XLEN-1:0]         rs1_data_o,
    output logic [XLEN-1:0]         rs2_data_o,
    input                           wen_i,
    input        [REG_ADDR_LEN-1:0] rd_addr_i,
    input        [XLEN-1:0]         rd_data_i,
    input                           dbg_en_i,
    input  dbg_req_t                dbg_cmd_i,
    output logic [XLEN-1:0]         dbg_rdata_o
);

    // x0 has no storage
    logic [XLEN-1:0] gpr [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                gpr[i] <= '0;
            end
        end else begin
            if (wen_i && rd_addr_i != '0) begin
                gpr[rd_addr_i] <= rd_data_i;
            end
            // Later assignment wins on the same register
            if (dbg_en_i && dbg_cmd_i.wr && dbg_cmd_i.addr != '0) begin
                gpr[dbg_cmd_i.addr] <= dbg_cmd_i.wdata;
            end
        end
    end

    assign rs1_data_o  = (rs1_addr_i == '0) ? '0 : gpr[rs1_addr_i];
    assign rs2_data_o  = (rs2_addr_i == '0) ? '0 : gpr[rs2_addr_i];
    assign dbg_rdata_o = (dbg_cmd_i.addr == '0) ? '0 : gpr[dbg_cmd_i.addr];

endmodule

// File: verilog/dbg_gpr_port.sv
module dbg_gpr_port
    import idu_pkg::*;
(
    input                   clk,
    input                   rst_n_i,
    input                   halted_i,
    input                   req_i,
    input  dbg_req_t        cmd_i,
    output logic            dbg_en_o,
    output dbg_req_t        dbg_cmd_o,
    input        [XLEN-1:0] rf_rdata_i,
    output logic            ack_o,
    output logic [XLEN-1:0] rdata_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_ACK
    } state_e;

    state_e state_q;
    logic   start;

    // Only accepted while the core is halted
    assign start = (state_q == ST_IDLE) && req_i && halted_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_ACCESS;
                    end
                end
                ST_ACCESS: state_q <= ST_ACK;
                default: begin
                    if (!req_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dbg_cmd_o <= cmd_i;
        end
        if (state_q == ST_ACCESS) begin
            rdata_o <= rf_rdata_i;
        end
    end

    assign dbg_en_o = (state_q == ST_ACCESS);
    assign ack_o    = (state_q == ST_ACK);

endmodule

// File: verilog/dec.sv
module dec
    import idu_pkg::*;
(
    input  inst_u                   inst_i,
    input                           inst_valid_i,
    output logic [REG_ADDR_LEN-1:0] rs1_addr_o,
    output logic [REG_ADDR_LEN-1:0] rs2_addr_o,
    output logic [REG_ADDR_LEN-1:0] rd_addr_o,
    output logic [XLEN-1:0]         imm_o,
    output exe_ctrl_t               exe_o,
    output mem_ctrl_t               mem_o,
    output wb_ctrl_t                wb_o,
    output logic                    ill_inst_o,
    output logic                    ecall_o,
    output logic                    ebreak_o,
    output logic                    fence_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       sys_base;
    logic       ill;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    alu_sel = alt ? ALU_SUB : ALU_ADD;
            3'd1:    alu_sel = ALU_SLL;
            3'd2:    alu_sel = ALU_SLT;
            3'd3:    alu_sel = ALU_SLTU;
            3'd4:    alu_sel = ALU_XOR;
            3'd5:    alu_sel = alt ? ALU_SRA : ALU_SRL;
            3'd6:    alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    // Word-aligned enables that the memory stage shifts
    function automatic logic [3:0] byte_en(input logic [1:0] size);
        case (size)
            2'b00:   byte_en = 4'b0001;
            2'b01:   byte_en = 4'b0011;
            default: byte_en = 4'b1111;
        endcase
    endfunction

    assign funct3     = inst_i.r.funct3;
    assign funct7     = inst_i.r.funct7;
    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;
    assign rd_addr_o  = inst_i.r.rd;
    assign sys_base   = (funct3 == 3'd0) && (inst_i.i.rs1 == '0) && (inst_i.i.rd == '0);

    always_comb begin
        case (inst_i.r.opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_MISC_MEM, OPC_SYSTEM:
                imm_o = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
            OPC_STORE:
                imm_o = {{20{inst_i.s.imm_11_5[6]}}, inst_i.s.imm_11_5, inst_i.s.imm_4_0};
            OPC_BRANCH:
                imm_o = {{19{inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
                         inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm_o = {inst_i.u.imm_31_12, 12'h000};
            OPC_JAL:
                imm_o = {{11{inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
                         inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};
            default:
                imm_o = '0;
        endcase
    end

    always_comb begin
        exe_o        = '0;
        exe_o.alu_op = ALU_ADD;
        exe_o.cmp_op = CMP_EQ;
        mem_o        = '0;
        wb_o         = '0;
        ill          = 1'b0;
        ecall_o      = 1'b0;
        ebreak_o     = 1'b0;
        fence_o      = 1'b0;
        case (inst_i.r.opcode)
            OPC_LUI: begin
                exe_o.rs1_zero_sel = 1'b1;
                exe_o.rs2_imm_sel  = 1'b1;
                wb_o.rd_wr         = 1'b1;
            end
            OPC_AUIPC, OPC_JAL: begin
                exe_o.pc_imm_sel  = 1'b1;
                exe_o.rs2_imm_sel = 1'b1;
                exe_o.jump        = (inst_i.r.opcode == OPC_JAL);
                wb_o.rd_wr        = 1'b1;
            end
            OPC_JALR: begin
                exe_o.rs2_imm_sel = 1'b1;
                exe_o.jump        = 1'b1;
                exe_o.jump_alu    = 1'b1;
                wb_o.rd_wr        = 1'b1;
                ill               = (funct3 != 3'd0);
            end
            OPC_BRANCH: begin
                // Target is pc plus offset
                exe_o.pc_imm_sel  = 1'b1;
                exe_o.rs2_imm_sel = 1'b1;
                exe_o.branch      = 1'b1;
                case (funct3)
                    3'd0:    exe_o.cmp_op = CMP_EQ;
                    3'd1:    exe_o.cmp_op = CMP_NE;
                    3'd4:    exe_o.cmp_op = CMP_LT;
                    3'd5:    exe_o.cmp_op = CMP_GE;
                    3'd6:    exe_o.cmp_op = CMP_LTU;
                    3'd7:    exe_o.cmp_op = CMP_GEU;
                    default: ill = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                exe_o.rs2_imm_sel  = 1'b1;
                mem_o.mem_req      = 1'b1;
                mem_o.mem_byte     = byte_en(funct3[1:0]);
                mem_o.mem_sign_ext = !funct3[2];
                wb_o.rd_wr         = 1'b1;
                wb_o.mem_cal_sel   = 1'b1;
                ill                = (funct3 == 3'd3) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                exe_o.rs2_imm_sel = 1'b1;
                mem_o.mem_req     = 1'b1;
                mem_o.mem_wr      = 1'b1;
                mem_o.mem_byte    = byte_en(funct3[1:0]);
                ill               = (funct3 > 3'd2);
            end
            OPC_OP_IMM: begin
                // Bit 30 selects SRAI only, elsewhere it is immediate
                exe_o.alu_op      = alu_sel(funct3, (funct3 == 3'd5) && funct7[5]);
                exe_o.rs2_imm_sel = 1'b1;
                wb_o.rd_wr        = 1'b1;
                ill = ((funct3 == 3'd1) && (funct7 != 7'b0000000)) ||
                      ((funct3 == 3'd5) && (funct7 != 7'b0000000) && (funct7 != 7'b0100000));
            end
            OPC_OP: begin
                exe_o.alu_op = alu_sel(funct3, funct7[5]);
                wb_o.rd_wr   = 1'b1;
                ill = (funct7 != 7'b0000000) &&
                      !((funct7 == 7'b0100000) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
            end
            OPC_MISC_MEM: begin
                fence_o = (funct3 == 3'd0);
                ill     = (funct3 != 3'd0);
            end
            OPC_SYSTEM: begin
                ecall_o  = sys_base && (inst_i.i.imm_11_0 == 12'h000);
                ebreak_o = sys_base && (inst_i.i.imm_11_0 == 12'h001);
                ill      = !(ecall_o || ebreak_o);
            end
            default: ill = 1'b1;
        endcase

        // Nothing issues from a bubble or a bad encoding
        if (ill || !inst_valid_i) begin
            exe_o.branch  = 1'b0;
            exe_o.jump    = 1'b0;
            mem_o.mem_req = 1'b0;
            mem_o.mem_wr  = 1'b0;
            wb_o.rd_wr    = 1'b0;
            ecall_o       = 1'b0;
            ebreak_o      = 1'b0;
            fence_o       = 1'b0;
        end
        ill_inst_o = ill && inst_valid_i;
    end

endmodule

// File: verilog/idu.sv
module idu
    import idu_pkg::*;
(
    input                           clk,
    input                           rst_n_i,
    input  inst_u                   inst_i,
    input                           inst_valid_i,
    input        [XLEN-1:0]         pc_i,
    output logic [XLEN-1:0]         pc_o,
    input                           rd_wr_i,
    input        [REG_ADDR_LEN-1:0] rd_addr_i,
    input        [XLEN-1:0]         rd_data_i,
    output logic [REG_ADDR_LEN-1:0] rs1_addr_o,
    output logic [REG_ADDR_LEN-1:0] rs2_addr_o,
    output logic [REG_ADDR_LEN-1:0] rd_addr_o,
    output logic [XLEN-1:0]         rs1_data_o,
    output logic [XLEN-1:0]         rs2_data_o,
    output logic [XLEN-1:0]         imm_o,
    output exe_ctrl_t               exe_o,
    output mem_ctrl_t               mem_o,
    output wb_ctrl_t                wb_o,
    output logic                    ill_inst_o,
    output logic                    ecall_o,
    output logic                    ebreak_o,
    output logic                    fence_o,
    input                           halted_i,
    input                           dbg_req_i,
    input  dbg_req_t                dbg_cmd_i,
    output logic                    dbg_ack_o,
    output logic [XLEN-1:0]         dbg_rdata_o
);

    logic            dbg_en;
    dbg_req_t        dbg_cmd;
    logic [XLEN-1:0] dbg_rf_rdata;

    // Not used in decode, forwarded to execute
    assign pc_o = pc_i;

    rfu u_rfu (
        .clk         ( clk          ),
        .rst_n_i     ( rst_n_i      ),
        .rs1_addr_i  ( rs1_addr_o   ),
        .rs2_addr_i  ( rs2_addr_o   ),
        .rs1_data_o  ( rs1_data_o   ),
        .rs2_data_o  ( rs2_data_o   ),
        .wen_i       ( rd_wr_i      ),
        .rd_addr_i   ( rd_addr_i    ),
        .rd_data_i   ( rd_data_i    ),
        .dbg_en_i    ( dbg_en       ),
        .dbg_cmd_i   ( dbg_cmd      ),
        .dbg_rdata_o ( dbg_rf_rdata )
    );

    dbg_gpr_port u_dbg (
        .clk        ( clk          ),
        .rst_n_i    ( rst_n_i      ),
        .halted_i   ( halted_i     ),
        .req_i      ( dbg_req_i    ),
        .cmd_i      ( dbg_cmd_i    ),
        .dbg_en_o   ( dbg_en       ),
        .dbg_cmd_o  ( dbg_cmd      ),
        .rf_rdata_i ( dbg_rf_rdata ),
        .ack_o      ( dbg_ack_o    ),
        .rdata_o    ( dbg_rdata_o  )
    );

    dec u_dec (
        .inst_i       ( inst_i       ),
        .inst_valid_i ( inst_valid_i ),
        .rs1_addr_o   ( rs1_addr_o   ),
        .rs2_addr_o   ( rs2_addr_o   ),
        .rd_addr_o    ( rd_addr_o    ),
        .imm_o        ( imm_o        ),
        .exe_o        ( exe_o        ),
        .mem_o        ( mem_o        ),
        .wb_o         ( wb_o         ),
        .ill_inst_o   ( ill_inst_o   ),
        .ecall_o      ( ecall_o      ),
        .ebreak_o     ( ebreak_o     ),
        .fence_o      ( fence_o      )
    );

endmodule

// File: test/tb_idu.sv
module tb_idu
    import idu_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 3000;

    logic                    clk;
    logic                    rst_n_i;
    inst_u                   inst_i;
    logic                    inst_valid_i;
    logic [XLEN-1:0]         pc_i;
    logic [XLEN-1:0]         pc_o;
    logic                    rd_wr_i;
    logic [REG_ADDR_LEN-1:0] rd_addr_i;
    logic [XLEN-1:0]         rd_data_i;
    logic [REG_ADDR_LEN-1:0] rs1_addr_o;
    logic [REG_ADDR_LEN-1:0] rs2_addr_o;
    logic [REG_ADDR_LEN-1:0] rd_addr_o;
    logic [XLEN-1:0]         rs1_data_o;
    logic [XLEN-1:0]         rs2_data_o;
    logic [XLEN-1:0]         imm_o;
    exe_ctrl_t               exe_o;
    mem_ctrl_t               mem_o;
    wb_ctrl_t                wb_o;
    logic                    ill_inst_o;
    logic                    ecall_o;
    logic                    ebreak_o;
    logic                    fence_o;
    logic                    halted_i;
    logic                    dbg_req_i;
    dbg_req_t                dbg_cmd_i;
    logic                    dbg_ack_o;
    logic [XLEN-1:0]         dbg_rdata_o;

    integer          seed;
    int              errors;
    int              errors_mark;
    int              passed;
    int              failed;
    int              cycles;
    logic [4:0]      r;
    logic [31:0]     d;
    logic [31:0]     got;
    logic [31:0]     gpr_model [32];

    idu dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped: no end reached within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Encoders scatter immediate bits per the RV32I formats
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        enc_r = {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] opc);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_u = {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // sel is {rs2_imm_sel, pc_imm_sel, rs1_zero_sel}, jmp is {jump, jump_alu}
    function automatic exe_ctrl_t pack_exe(input alu_op_e op, input logic [2:0] sel,
                                           input logic br, input cmp_op_e cmp,
                                           input logic [1:0] jmp);
        pack_exe = {op, sel, br, cmp, jmp};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        if (errors == errors_mark) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_mark);
        end
        errors_mark = errors;
    endtask

    task automatic read_check(input logic [4:0] r1, input logic [4:0] r2);
        @(negedge clk);
        inst_i       = enc_r(7'h00, r2, r1, 3'd0, 5'd0, OPC_OP);
        inst_valid_i = 1'b1;
        #1;
        check_eq("rs1_data_o", gpr_model[r1], rs1_data_o);
        check_eq("rs2_data_o", gpr_model[r2], rs2_data_o);
    endtask

    // Without a bypass the old word is read in the write cycle
    task automatic wb_write(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        rd_wr_i   = 1'b1;
        rd_addr_i = addr;
        rd_data_i = data;
        inst_i    = enc_r(7'h00, addr, addr, 3'd0, 5'd0, OPC_OP);
        #1;
        check_eq("rs1_data_o", gpr_model[addr], rs1_data_o);
        @(negedge clk);
        rd_wr_i = 1'b0;
        if (addr != 5'd0) begin
            gpr_model[addr] = data;
        end
        #1;
        check_eq("rs1_data_o", gpr_model[addr], rs1_data_o);
        check_eq("rs2_data_o", gpr_model[addr], rs2_data_o);
    endtask

    task automatic dbg_access(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                              input int hold, input logic coll, input logic [31:0] coll_data,
                              output logic [31:0] rdata);
        @(negedge clk);
        dbg_req_i = 1'b1;
        dbg_cmd_i = '{wr: wr, addr: addr, wdata: wdata};
        if (hold > 0) begin
            halted_i = 1'b0;
            repeat (hold) begin
                @(negedge clk);
                check_eq("dbg_ack_o", 1'b0, dbg_ack_o);
            end
            halted_i = 1'b1;
        end
        @(negedge clk);
        check_eq("dbg_ack_o", 1'b0, dbg_ack_o);
        if (coll) begin
            rd_wr_i   = 1'b1;
            rd_addr_i = addr;
            rd_data_i = coll_data;
        end
        @(negedge clk);
        rd_wr_i = 1'b0;
        check_eq("dbg_ack_o", 1'b1, dbg_ack_o);
        rdata     = dbg_rdata_o;
        dbg_req_i = 1'b0;
        if (wr && addr != 5'd0) begin
            gpr_model[addr] = wdata;
        end
        @(negedge clk);
        check_eq("dbg_ack_o", 1'b0, dbg_ack_o);
    endtask

    task automatic idle_check(input logic [31:0] w);
        @(negedge clk);
        inst_i       = w;
        inst_valid_i = 1'b0;
        pc_i         = w ^ 32'h0000_1000;
        #1;
        check_eq("pc_o", pc_i, pc_o);
        check_eq("wb_o.rd_wr", 1'b0, wb_o.rd_wr);
        check_eq("mem_o.mem_req", 1'b0, mem_o.mem_req);
        check_eq("mem_o.mem_wr", 1'b0, mem_o.mem_wr);
        check_eq("exe_o.branch", 1'b0, exe_o.branch);
        check_eq("exe_o.jump", 1'b0, exe_o.jump);
        check_eq("ill_inst_o", 1'b0, ill_inst_o);
        check_eq("ecall_o", 1'b0, ecall_o);
        check_eq("ebreak_o", 1'b0, ebreak_o);
        check_eq("fence_o", 1'b0, fence_o);
    endtask

    task automatic fmt_check(input int k);
        logic [31:0] f;
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] imm;
        f = $random(seed);
        v = $random(seed);
        case (k)
            0: w = enc_r(7'h00, f[9:5], f[4:0], f[17:15], f[14:10], OPC_OP);
            1: w = enc_i(v[11:0], f[4:0], 3'd0, f[14:10], OPC_OP_IMM);
            2: w = enc_s(v[11:0], f[9:5], f[4:0], 3'd2, OPC_STORE);
            3: w = enc_b(v[12:0], f[9:5], f[4:0], 3'd0);
            4: w = enc_u(v[31:12], f[14:10], OPC_LUI);
            default: w = enc_j(v[20:0], f[14:10]);
        endcase
        case (k)
            3: imm = {{19{v[12]}}, v[12:1], 1'b0};
            4: imm = {v[31:12], 12'h000};
            5: imm = {{11{v[20]}}, v[20:1], 1'b0};
            default: imm = {{20{v[11]}}, v[11:0]};
        endcase
        @(negedge clk);
        inst_i       = w;
        inst_valid_i = 1'b1;
        #1;
        if (k != 0) check_eq("imm_o", imm, imm_o);
        if (k < 4) check_eq("rs1_addr_o", f[4:0], rs1_addr_o);
        if (k == 0 || k == 2 || k == 3) check_eq("rs2_addr_o", f[9:5], rs2_addr_o);
        if (k == 0 || k == 1 || k > 3) check_eq("rd_addr_o", f[14:10], rd_addr_o);
    endtask

    // m is {mem_req, mem_wr, mem_byte, mem_sign_ext}, f is {ill, ecall, ebreak, fence}
    task automatic ctrl_check(input logic [31:0] w, input exe_ctrl_t e, input logic [6:0] m,
                              input logic [1:0] b, input logic [3:0] f);
        @(negedge clk);
        inst_i       = w;
        inst_valid_i = 1'b1;
        #1;
        check_eq("exe_o", e, exe_o);
        check_eq("mem_o", m, mem_o);
        check_eq("wb_o", b, wb_o);
        check_eq("{ill_inst_o,ecall_o,ebreak_o,fence_o}", f,
                 {ill_inst_o, ecall_o, ebreak_o, fence_o});
    endtask

    task automatic ill_check(input logic [31:0] w);
        @(negedge clk);
        inst_i       = w;
        inst_valid_i = 1'b1;
        #1;
        check_eq("ill_inst_o", 1'b1, ill_inst_o);
        check_eq("wb_o.rd_wr", 1'b0, wb_o.rd_wr);
        check_eq("mem_o.mem_req", 1'b0, mem_o.mem_req);
        check_eq("exe_o.branch", 1'b0, exe_o.branch);
        check_eq("exe_o.jump", 1'b0, exe_o.jump);
    endtask

    initial begin
        seed         = 32'hc970;
        errors       = 0;
        errors_mark  = 0;
        passed       = 0;
        failed       = 0;
        cycles       = 0;
        rst_n_i      = 1'b0;
        inst_i       = '0;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        rd_wr_i      = 1'b0;
        rd_addr_i    = '0;
        rd_data_i    = '0;
        halted_i     = 1'b0;
        dbg_req_i    = 1'b0;
        dbg_cmd_i    = '0;
        for (int i = 0; i < 32; i++) begin
            gpr_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        check_eq("dbg_ack_o", 1'b0, dbg_ack_o);
        idle_check(enc_j(21'h01234, 5'd1));
        idle_check(enc_s(12'h010, 5'd2, 5'd3, 3'd2, OPC_STORE));
        idle_check(enc_b(13'h0040, 5'd2, 5'd3, 3'd1));
        idle_check(enc_i(12'h000, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));
        idle_check(enc_i(12'h0ff, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM));
        idle_check(32'hffff_ffff);
        for (int i = 0; i < 32; i++) begin
            read_check(i[4:0], 5'd31 - i[4:0]);
        end
        test_done("reset_idle");

        repeat (8) begin
            d = $random(seed);
            wb_write(d[4:0], $random(seed));
        end
        wb_write(5'd0, 32'hdead_beef);
        test_done("writeback");

        @(negedge clk);
        halted_i = 1'b1;
        d        = $random(seed);
        r        = (d[4:0] == 5'd0) ? 5'd7 : d[4:0];
        dbg_access(1'b1, r, d, 0, 1'b0, '0, got);
        dbg_access(1'b0, r, '0, 0, 1'b0, '0, got);
        check_eq("dbg_rdata_o", d, got);
        read_check(r, r);
        dbg_access(1'b0, r, '0, 4, 1'b0, '0, got);
        check_eq("dbg_rdata_o", d, got);
        d = $random(seed);
        dbg_access(1'b1, r, d, 0, 1'b1, ~d, got);
        read_check(r, r);
        test_done("debug_port");

        for (int i = 0; i < 36; i++) begin
            fmt_check(i % 6);
        end
        test_done("formats");

        ctrl_check(enc_u(20'h12345, 5'd5, OPC_LUI),
                   pack_exe(ALU_ADD, 3'b101, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_u(20'hfedcb, 5'd5, OPC_AUIPC),
                   pack_exe(ALU_ADD, 3'b110, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_j(21'h00800, 5'd5),
                   pack_exe(ALU_ADD, 3'b110, 1'b0, CMP_EQ, 2'b10), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_i(12'h004, 5'd3, 3'd0, 5'd5, OPC_JALR),
                   pack_exe(ALU_ADD, 3'b100, 1'b0, CMP_EQ, 2'b11), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_b(13'h1ffc, 5'd4, 5'd3, 3'd6),
                   pack_exe(ALU_ADD, 3'b110, 1'b1, CMP_LTU, 2'b00), 7'h00, 2'b00, 4'h0);
        ctrl_check(enc_i(12'h010, 5'd3, 3'd0, 5'd5, OPC_LOAD),
                   pack_exe(ALU_ADD, 3'b100, 1'b0, CMP_EQ, 2'b00), 7'b1_0_0001_1, 2'b11, 4'h0);
        ctrl_check(enc_i(12'h010, 5'd3, 3'd5, 5'd5, OPC_LOAD),
                   pack_exe(ALU_ADD, 3'b100, 1'b0, CMP_EQ, 2'b00), 7'b1_0_0011_0, 2'b11, 4'h0);
        ctrl_check(enc_s(12'h020, 5'd4, 5'd3, 3'd1, OPC_STORE),
                   pack_exe(ALU_ADD, 3'b100, 1'b0, CMP_EQ, 2'b00), 7'b1_1_0011_0, 2'b00, 4'h0);
        // Bit 30 set on ADDI is only immediate
        ctrl_check(enc_i(12'h400, 5'd3, 3'd0, 5'd5, OPC_OP_IMM),
                   pack_exe(ALU_ADD, 3'b100, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_i(12'h405, 5'd3, 3'd5, 5'd5, OPC_OP_IMM),
                   pack_exe(ALU_SRA, 3'b100, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd5, OPC_OP),
                   pack_exe(ALU_SUB, 3'b000, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_r(7'h00, 5'd4, 5'd3, 3'd3, 5'd5, OPC_OP),
                   pack_exe(ALU_SLTU, 3'b000, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b10, 4'h0);
        ctrl_check(enc_i(12'h000, 5'd0, 3'd0, 5'd0, OPC_SYSTEM),
                   pack_exe(ALU_ADD, 3'b000, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b00, 4'b0100);
        ctrl_check(enc_i(12'h001, 5'd0, 3'd0, 5'd0, OPC_SYSTEM),
                   pack_exe(ALU_ADD, 3'b000, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b00, 4'b0010);
        ctrl_check(enc_i(12'h0ff, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM),
                   pack_exe(ALU_ADD, 3'b000, 1'b0, CMP_EQ, 2'b00), 7'h00, 2'b00, 4'b0001);
        test_done("control");

        ill_check(32'hffff_ffff);
        ill_check(enc_r(7'h01, 5'd4, 5'd3, 3'd0, 5'd5, OPC_OP));
        ill_check(enc_r(7'h20, 5'd4, 5'd3, 3'd1, 5'd5, OPC_OP));
        ill_check(enc_i(12'h021, 5'd3, 3'd1, 5'd5, OPC_OP_IMM));
        ill_check(enc_i(12'h421, 5'd3, 3'd5, 5'd5, OPC_OP_IMM));
        ill_check(enc_i(12'h000, 5'd3, 3'd3, 5'd5, OPC_LOAD));
        ill_check(enc_i(12'h000, 5'd3, 3'd6, 5'd5, OPC_LOAD));
        ill_check(enc_s(12'h000, 5'd4, 5'd3, 3'd3, OPC_STORE));
        ill_check(enc_b(13'h0010, 5'd4, 5'd3, 3'd2));
        ill_check(enc_i(12'h000, 5'd3, 3'd1, 5'd5, OPC_JALR));
        ill_check(enc_i(12'h300, 5'd3, 3'd1, 5'd5, OPC_SYSTEM));
        test_done("illegal");

        $display("tests passed %0d, tests failed %0d, failed checks %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/idu_pkg.sv
verilog/rfu.sv
verilog/dbg_gpr_port.sv
verilog/dec.sv
verilog/idu.sv
test/tb_idu.sv

// File: Bender.yml
package:
  name: idu

sources:
  - verilog/idu_pkg.sv
  - verilog/rfu.sv
  - verilog/dbg_gpr_port.sv
  - verilog/dec.sv
  - verilog/idu.sv
  - target: test
    files:
      - test/tb_idu.sv
